// File: sim.f
+incdir+rtl
rtl/ooo_issue_pkg.sv
rtl/reservation_station.sv
rtl/add_unit.sv
rtl/mul_sequencer_fsm.sv
rtl/mul_iter_counter.sv
rtl/mul_datapath.sv
rtl/cdb_arbiter.sv
rtl/issue_top.sv
testbench/issue_assert.sv
testbench/issue_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the issue stage testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module issue_tb -o issue_sim \
    && ./obj_dir/issue_sim | tee /dev/stderr | grep -q "^STATUS: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: testbench/issue_tb.sv
`include "ooo_settings.svh"

module issue_tb import ooo_issue_pkg::*; ();

    localparam int N_TESTS   = 5;
    localparam int TEST_SPAN = 4;       // dispatch rounds per test
    localparam int WATCHDOG  = N_TESTS * (`MUL_ITERS + 40) * TEST_SPAN * 10;
    localparam int N_TAGS    = 1 << `PTAG_BITS;

    localparam dispatch_t NO_DISP = '0;
    localparam cdb_t      NO_WAKE = '0;

    logic        clk;
    logic        rst;
    dispatch_t   dispatch;
    cdb_t        ext_wake;
    logic        add_full;
    logic        mul_full;
    cdb_t        cdb;

    logic [31:0] exp_val [N_TAGS];      // scoreboard keyed by pd
    rob_id_t     exp_rob [N_TAGS];
    logic        exp_live [N_TAGS];
    int          pending;
    int          value_errors;
    int          other_errors;
    int          assert_errors;
    rob_id_t     rob_next;

    issue_top dut (
        .clk(clk), .rst(rst), .dispatch(dispatch), .ext_wake(ext_wake),
        .add_full(add_full), .mul_full(mul_full), .cdb(cdb)
    );

    always #5 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            value_errors++;
        end
    endtask

    // reference model of the operation rules
    function automatic logic [31:0] ref_add(input add_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] ref_mul(input mul_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        logic [63:0] p;
        p = {32'b0, a} * {32'b0, b};
        return (op == OP_MULHU) ? p[63:32] : p[31:0];
    endfunction

    function automatic src_t ready_src(input logic [31:0] v);
        src_t s;
        s.tag   = '0;
        s.ready = 1'b1;
        s.value = v;
        return s;
    endfunction

    function automatic src_t wait_src(input int tag);
        src_t s;
        s.tag   = ptag_t'(tag);
        s.ready = 1'b0;
        s.value = '0;
        return s;
    endfunction

    function automatic cdb_t make_wake(input int tag, input logic [31:0] v);
        cdb_t w;
        w.valid  = 1'b1;
        w.pd     = ptag_t'(tag);
        w.rob_id = '0;
        w.value  = v;
        return w;
    endfunction

    function automatic dispatch_t make_op(input unit_sel_t unit, input add_op_t aop,
                                          input mul_op_t mop, input int pd,
                                          input src_t s1, input src_t s2);
        dispatch_t d;
        d.valid    = 1'b1;
        d.unit_sel = unit;
        d.src1     = s1;
        d.src2     = s2;
        d.pd       = ptag_t'(pd);
        d.rob_id   = rob_next;
        d.add_op   = aop;
        d.mul_op   = mop;
        return d;
    endfunction

    task automatic expect_result(input ptag_t pd, input rob_id_t rob, input logic [31:0] val);
        if (exp_live[pd])
        begin
            $display("tag %0d was reused while its result was still pending", pd);
            other_errors++;
        end
        else
            pending++;
        exp_live[pd] = 1'b1;
        exp_val[pd]  = val;
        exp_rob[pd]  = rob;
    endtask

    // one-cycle strobe of dispatch and external wakeup
    task automatic send_op(input dispatch_t d, input cdb_t w);
        @(posedge clk);
        dispatch <= d;
        ext_wake <= w;
        if (d.valid)
            rob_next++;
        @(posedge clk);
        dispatch.valid <= 1'b0;
        ext_wake.valid <= 1'b0;
    endtask

    task automatic issue_add(input add_op_t op, input int pd, input logic [31:0] a,
                             input logic [31:0] b);
        dispatch_t d;
        d = make_op(UNIT_ADD, op, OP_MUL, pd, ready_src(a), ready_src(b));
        expect_result(d.pd, d.rob_id, ref_add(op, a, b));
        send_op(d, NO_WAKE);
    endtask

    task automatic issue_mul(input mul_op_t op, input int pd, input logic [31:0] a,
                             input logic [31:0] b);
        dispatch_t d;
        d = make_op(UNIT_MUL, OP_ADD, op, pd, ready_src(a), ready_src(b));
        expect_result(d.pd, d.rob_id, ref_mul(op, a, b));
        send_op(d, NO_WAKE);
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (pending != 0 && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (pending != 0)
        begin
            $display("%0d results did not reach the cdb within %0d cycles", pending, limit);
            other_errors++;
        end
    endtask

    // cdb monitor retires scoreboard entries
    always @(negedge clk)
    begin
        if (!rst && cdb.valid)
        begin
            if (!exp_live[cdb.pd])
            begin
                $display("unexpected broadcast on the cdb for tag %0d", cdb.pd);
                other_errors++;
            end
            else
            begin
                check_eq("cdb.value", cdb.value, exp_val[cdb.pd]);
                check_eq("cdb.rob_id", 32'(cdb.rob_id), 32'(exp_rob[cdb.pd]));
                exp_live[cdb.pd] = 1'b0;
                pending--;
            end
        end
    end

    task automatic test_reset();
        @(negedge clk);
        check_eq("cdb.valid", 32'(cdb.valid), 32'd0);
        check_eq("add_full", 32'(add_full), 32'd0);
        check_eq("mul_full", 32'(mul_full), 32'd0);
    endtask

    task automatic test_add_ops();
        dispatch_t   d;
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        for (int k = 0; k < 6; k++)
        begin
            a = $urandom;
            b = $urandom;
            d = make_op(UNIT_ADD, add_op_t'(k), OP_MUL, k + 1, ready_src(a), ready_src(b));
            expect_result(d.pd, d.rob_id, ref_add(d.add_op, a, b));
            send_op(d, NO_WAKE);
            n = 1;                              // edges since the strobe edge
            @(negedge clk);
            while (!cdb.valid && n < 20)
            begin
                n++;
                @(negedge clk);
            end
            if (!cdb.valid)
            begin
                $display("add result for tag %0d never reached the cdb", d.pd);
                other_errors++;
            end
            else
            begin
                check_eq("add latency", 32'(n), 32'd3);
                check_eq("cdb.pd", 32'(cdb.pd), 32'(d.pd));
            end
            wait_drain(10);
        end
    endtask

    task automatic test_wakeup();
        dispatch_t   d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] v;
        logic [31:0] v2;
        a  = $urandom;
        b  = $urandom;
        v  = $urandom;
        d  = make_op(UNIT_ADD, OP_SUB, OP_MUL, 20, wait_src(50), ready_src(b));
        expect_result(d.pd, d.rob_id, v - b);
        send_op(d, NO_WAKE);
        repeat (3) @(posedge clk);
        send_op(NO_DISP, make_wake(50, v));     // wake a parked entry
        v  = $urandom;
        d  = make_op(UNIT_ADD, OP_XOR, OP_MUL, 21, ready_src(a), wait_src(51));
        expect_result(d.pd, d.rob_id, a ^ v);
        send_op(d, make_wake(51, v));           // wakeup in the dispatch cycle
        issue_add(OP_ADD, 22, a, b);
        v2 = $urandom;
        d  = make_op(UNIT_ADD, OP_OR, OP_MUL, 23, wait_src(22), wait_src(52));
        expect_result(d.pd, d.rob_id, (a + b) | v2);
        send_op(d, NO_WAKE);
        send_op(NO_DISP, make_wake(52, v2));
        wait_drain(30);
    endtask

    task automatic test_mul();
        logic [31:0] a;
        logic [31:0] b;
        for (int k = 0; k < 4; k++)
        begin
            a = (k < 2) ? 32'hffff_ffff : $urandom;
            b = (k < 2) ? 32'hffff_ffff : $urandom;
            issue_mul((k % 2 == 1) ? OP_MULHU : OP_MUL, 40 + k, a, b);
            wait_drain(`MUL_ITERS + 20);
        end
    endtask

    // steady add stream across one multiply with the offset shifting which add collides
    task automatic run_mix_round(input int offset, input int mul_pd);
        issue_mul(mul_op_t'(mul_pd % 2), mul_pd, $urandom, $urandom);
        repeat (offset) @(posedge clk);
        for (int k = 0; k < 20; k++)
            issue_add(add_op_t'($urandom_range(5, 0)), k + 1, $urandom, $urandom);
        wait_drain(`MUL_ITERS + 20);
    endtask

    task automatic test_fill_contention();
        dispatch_t   d;
        logic [31:0] b [4];
        logic [31:0] w [4];
        int          n;
        for (int i = 0; i < 4; i++)
        begin
            b[i] = $urandom;
            w[i] = $urandom;
            d = make_op(UNIT_ADD, OP_ADD, OP_MUL, 30 + i, wait_src(60 + i), ready_src(b[i]));
            expect_result(d.pd, d.rob_id, w[i] + b[i]);
            send_op(d, NO_WAKE);
        end
        @(negedge clk);
        check_eq("add_full", 32'(add_full), 32'd1);
        send_op(NO_DISP, make_wake(60, w[0]));
        n = 0;
        while (add_full && n < 8)
        begin
            @(negedge clk);
            n++;
        end
        if (add_full)
        begin
            $display("add_full stayed high after an entry issued");
            other_errors++;
        end
        for (int i = 1; i < 4; i++)
            send_op(NO_DISP, make_wake(60 + i, w[i]));
        wait_drain(20);
        run_mix_round(0, 44);
        run_mix_round(2, 45);
    endtask

    initial
    begin
        #(WATCHDOG);
        $display("watchdog expired after %0d time units, the run is stuck", WATCHDOG);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        dispatch     = '0;
        ext_wake     = '0;
        pending      = 0;
        value_errors = 0;
        other_errors = 0;
        rob_next     = '0;
        for (int i = 0; i < N_TAGS; i++)
            exp_live[i] = 1'b0;
        void'($urandom(32'h6395f71a));
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_add_ops();
        test_wakeup();
        test_mul();
        test_fill_contention();
        repeat (5) @(posedge clk);
        if (pending != 0)
        begin
            $display("%0d expected results never appeared on the cdb", pending);
            other_errors++;
        end
        assert_errors = dut.u_assert.fail_count;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errors, other_errors, assert_errors);
        if (value_errors == 0 && other_errors == 0 && assert_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: testbench/issue_assert.sv
`include "ooo_settings.svh"

module issue_assert import ooo_issue_pkg::*; (
    input logic      clk,
    input logic      rst,
    input dispatch_t dispatch,
    input logic      add_full,
    input logic      mul_full,
    input logic      add_stall,
    input cdb_t      add_result,
    input logic      mul_issue_valid,
    input logic      mul_busy,
    input logic      mul_done
);

    int fail_count = 0;

    a_add_not_full: assert property (@(posedge clk) disable iff (rst)
        dispatch.valid && dispatch.unit_sel == UNIT_ADD |-> !add_full)
    else
    begin
        $error("dispatch strobed into a full add station");
        fail_count++;
    end

    a_mul_not_full: assert property (@(posedge clk) disable iff (rst)
        dispatch.valid && dispatch.unit_sel == UNIT_MUL |-> !mul_full)
    else
    begin
        $error("dispatch strobed into a full multiply station");
        fail_count++;
    end

    // a stalled add unit takes no new issue and holds its result
    a_add_stall: assert property (@(posedge clk) disable iff (rst)
        add_stall |=> $stable(add_result))
    else
    begin
        $error("add unit accepted an issue while the arbiter stalled it");
        fail_count++;
    end

    // an accepted multiply keeps the sequencer busy until its own done strobe
    a_mul_busy: assert property (@(posedge clk) disable iff (rst)
        mul_issue_valid |=> mul_busy ##(`MUL_ITERS) mul_done)
    else
    begin
        $error("multiply issue overlapped a busy sequencer or missed its done strobe");
        fail_count++;
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        mul_done |=> !mul_done)
    else
    begin
        $error("mul_done held longer than one cycle");
        fail_count++;
    end

endmodule

bind issue_top issue_assert u_assert (
    .clk(clk), .rst(rst), .dispatch(dispatch), .add_full(add_full),
    .mul_full(mul_full), .add_stall(add_stall), .add_result(add_result),
    .mul_issue_valid(mul_issue_valid), .mul_busy(mul_busy), .mul_done(mul_done)
);

// File: rtl/issue_top.sv
`include "ooo_settings.svh"

module issue_top import ooo_issue_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  dispatch_t dispatch,
    input  cdb_t      ext_wake,
    output logic      add_full,
    output logic      mul_full,
    output cdb_t      cdb
);

    logic        add_we;
    logic        mul_we;

    logic        add_issue_valid;
    logic [31:0] add_a;
    logic [31:0] add_b;
    ptag_t       add_pd;
    rob_id_t     add_rob;
    add_op_t     add_op;
    logic        add_stall;
    cdb_t        add_result;

    logic        mul_issue_valid;
    logic [31:0] mul_a;
    logic [31:0] mul_b;
    ptag_t       mul_pd;
    rob_id_t     mul_rob;
    mul_op_t     mul_op;
    logic        mul_load;
    logic        mul_step;
    logic        mul_count_start;
    logic        mul_busy;
    logic        mul_done;
    logic        mul_last_iter;
    ptag_t       mul_done_pd;
    rob_id_t     mul_done_rob;
    mul_op_t     mul_done_op;
    logic [63:0] mul_product;
    cdb_t        mul_result;

    assign add_we = dispatch.valid && (dispatch.unit_sel == UNIT_ADD);
    assign mul_we = dispatch.valid && (dispatch.unit_sel == UNIT_MUL);

    reservation_station #(.DEPTH(`ADD_RS_DEPTH), .payload_t(add_op_t)) u_add_rs (
        .clk(clk), .rst(rst), .disp_we(add_we), .disp(dispatch),
        .disp_payload(dispatch.add_op), .cdb(cdb), .ext_wake(ext_wake),
        .unit_busy(add_stall), .full(add_full), .issue_valid(add_issue_valid),
        .issue_a(add_a), .issue_b(add_b), .issue_pd(add_pd), .issue_rob(add_rob),
        .issue_payload(add_op)
    );

    reservation_station #(.DEPTH(`MUL_RS_DEPTH), .payload_t(mul_op_t)) u_mul_rs (
        .clk(clk), .rst(rst), .disp_we(mul_we), .disp(dispatch),
        .disp_payload(dispatch.mul_op), .cdb(cdb), .ext_wake(ext_wake),
        .unit_busy(mul_busy), .full(mul_full), .issue_valid(mul_issue_valid),
        .issue_a(mul_a), .issue_b(mul_b), .issue_pd(mul_pd), .issue_rob(mul_rob),
        .issue_payload(mul_op)
    );

    add_unit u_add_unit (
        .clk(clk), .rst(rst), .issue_valid(add_issue_valid), .a(add_a), .b(add_b),
        .pd(add_pd), .rob_id(add_rob), .op(add_op), .stall(add_stall),
        .result(add_result)
    );

    mul_sequencer_fsm u_mul_fsm (
        .clk(clk), .rst(rst), .issue_valid(mul_issue_valid), .pd(mul_pd),
        .rob_id(mul_rob), .op(mul_op), .last_iter(mul_last_iter), .load(mul_load),
        .step(mul_step), .count_start(mul_count_start), .busy(mul_busy),
        .done(mul_done), .done_pd(mul_done_pd), .done_rob(mul_done_rob),
        .done_op(mul_done_op)
    );

    mul_iter_counter u_mul_cnt (
        .clk(clk), .rst(rst), .start(mul_count_start), .step(mul_step),
        .last_iter(mul_last_iter)
    );

    mul_datapath u_mul_dp (
        .clk(clk), .rst(rst), .load(mul_load), .step(mul_step), .a(mul_a), .b(mul_b),
        .product(mul_product)
    );

    // pick the product half the instruction asked for
    assign mul_result = '{valid:  mul_done,
                          pd:     mul_done_pd,
                          rob_id: mul_done_rob,
                          value:  (mul_done_op == OP_MULHU) ? mul_product[63:32]
                                                            : mul_product[31:0]};

    cdb_arbiter u_arb (
        .clk(clk), .rst(rst), .add_result(add_result), .mul_result(mul_result),
        .add_stall(add_stall), .cdb(cdb)
    );

endmodule

// File: rtl/cdb_arbiter.sv
module cdb_arbiter import ooo_issue_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  cdb_t add_result,
    input  cdb_t mul_result,
    output logic add_stall,
    output cdb_t cdb
);

    logic hold_valid;
    cdb_t hold_q;
    logic add_lost;

    // add result is frozen while held off, so it only counts when hold is empty
    assign add_lost  = mul_result.valid && add_result.valid && !hold_valid;
    assign add_stall = hold_valid;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cdb        <= '0;
            hold_valid <= 1'b0;
        end
        else if (mul_result.valid)
        begin
            cdb <= mul_result;                 // multiply always wins
            if (add_lost)
                hold_valid <= 1'b1;
        end
        else if (hold_valid)
        begin
            cdb        <= hold_q;
            hold_valid <= 1'b0;
        end
        else
            cdb <= add_result;
    end

    always_ff @(posedge clk)
    begin
        if (add_lost)
            hold_q <= add_result;
    end

endmodule

// File: rtl/mul_datapath.sv
module mul_datapath (
    input  logic        clk,
    input  logic        rst,
    input  logic        load,
    input  logic        step,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [63:0] product
);

    logic [63:0] mcand;      // shifts left one bit per step
    logic [31:0] mplier;     // shifts right, lsb picks the add
    logic [63:0] acc;

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            mcand  <= {32'b0, a};
            mplier <= b;
        end
        else if (step)
        begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            acc <= '0;
        else if (load)
            acc <= '0;
        else if (step && mplier[0])
            acc <= acc + mcand;
    end

    // unsigned product, complete after the last step
    assign product = acc;

endmodule

// File: rtl/mul_iter_counter.sv
`include "ooo_settings.svh"

module mul_iter_counter (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic step,
    output logic last_iter
);

    localparam int CNT_BITS = $clog2(`MUL_ITERS);

    logic [CNT_BITS-1:0] count;

    always_ff @(posedge clk)
    begin
        if (rst)
            count <= '0;
        else if (start)
            count <= CNT_BITS'(`MUL_ITERS - 1);
        else if (step && count != '0)
            count <= count - 1'b1;     // parks at zero
    end

    assign last_iter = (count == '0);

endmodule

// File: rtl/mul_sequencer_fsm.sv
module mul_sequencer_fsm import ooo_issue_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issue_valid,
    input  ptag_t   pd,
    input  rob_id_t rob_id,
    input  mul_op_t op,
    input  logic    last_iter,
    output logic    load,
    output logic    step,
    output logic    count_start,
    output logic    busy,
    output logic    done,
    output ptag_t   done_pd,
    output rob_id_t done_rob,
    output mul_op_t done_op
);

    typedef enum logic [1:0] {IDLE, RUN, DONE} state_t;

    state_t state;
    state_t state_next;

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:    if (issue_valid) state_next = RUN;
            RUN:     if (last_iter) state_next = DONE;   // final step happens this cycle
            DONE:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    // tag and op ride alongside the datapath until done
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            done_pd  <= pd;
            done_rob <= rob_id;
            done_op  <= op;
        end
    end

    assign load        = (state == IDLE) && issue_valid;
    assign count_start = load;
    assign step        = (state == RUN);
    assign busy        = (state != IDLE);
    assign done        = (state == DONE);

endmodule

// File: rtl/add_unit.sv
module add_unit import ooo_issue_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  ptag_t       pd,
    input  rob_id_t     rob_id,
    input  add_op_t     op,
    input  logic        stall,
    output cdb_t        result
);

    logic [31:0] alu_out;
    logic        valid_q;
    ptag_t       pd_q;
    rob_id_t     rob_q;
    logic [31:0] value_q;

    always_comb
    begin
        case (op)
            OP_ADD:  alu_out = a + b;
            OP_SUB:  alu_out = a - b;
            OP_AND:  alu_out = a & b;
            OP_OR:   alu_out = a | b;
            OP_XOR:  alu_out = a ^ b;
            OP_SLT:  alu_out = {31'b0, $signed(a) < $signed(b)};
            default: alu_out = a + b;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            valid_q <= 1'b0;
        else if (!stall)
            valid_q <= issue_valid;      // frozen while the arbiter holds us off
    end

    always_ff @(posedge clk)
    begin
        if (!stall && issue_valid)
        begin
            pd_q    <= pd;
            rob_q   <= rob_id;
            value_q <= alu_out;
        end
    end

    assign result = '{valid: valid_q, pd: pd_q, rob_id: rob_q, value: value_q};

endmodule

// File: rtl/reservation_station.sv
module reservation_station import ooo_issue_pkg::*; #(
    parameter int  DEPTH     = 4,
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        disp_we,
    input  dispatch_t   disp,
    input  payload_t    disp_payload,
    input  cdb_t        cdb,
    input  cdb_t        ext_wake,
    input  logic        unit_busy,
    output logic        full,
    output logic        issue_valid,
    output logic [31:0] issue_a,
    output logic [31:0] issue_b,
    output ptag_t       issue_pd,
    output rob_id_t     issue_rob,
    output payload_t    issue_payload
);

    localparam int IDX_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef struct packed {
        src_t     src1;
        src_t     src2;
        ptag_t    pd;
        rob_id_t  rob_id;
        payload_t payload;
    } entry_t;

    entry_t              entries [DEPTH];
    logic [DEPTH-1:0]    busy;
    logic [IDX_BITS-1:0] free_idx;
    logic [IDX_BITS-1:0] sel_idx;
    logic                any_ready;
    entry_t              new_entry;

    // tag match against both broadcasts, the bus wins if both hit
    function automatic src_t wake(input src_t s, input cdb_t a, input cdb_t b);
        src_t r;
        r = s;
        if (!s.ready && a.valid && a.pd == s.tag)
        begin
            r.ready = 1'b1;
            r.value = a.value;
        end
        else if (!s.ready && b.valid && b.pd == s.tag)
        begin
            r.ready = 1'b1;
            r.value = b.value;
        end
        return r;
    endfunction

    // lowest free slot, scanned downward so the smallest index sticks
    always_comb
    begin
        full     = 1'b1;
        free_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                full     = 1'b0;
                free_idx = IDX_BITS'(i);
            end
        end
    end

    always_comb
    begin
        any_ready = 1'b0;
        sel_idx   = '0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (busy[i] && entries[i].src1.ready && entries[i].src2.ready)
            begin
                any_ready = 1'b1;
                sel_idx   = IDX_BITS'(i);
            end
        end
    end

    // incoming dispatch sees this cycle's wakeups too
    always_comb
    begin
        new_entry.src1    = wake(disp.src1, cdb, ext_wake);
        new_entry.src2    = wake(disp.src2, cdb, ext_wake);
        new_entry.pd      = disp.pd;
        new_entry.rob_id  = disp.rob_id;
        new_entry.payload = disp_payload;
    end

    assign issue_valid   = any_ready && !unit_busy;
    assign issue_a       = entries[sel_idx].src1.value;
    assign issue_b       = entries[sel_idx].src2.value;
    assign issue_pd      = entries[sel_idx].pd;
    assign issue_rob     = entries[sel_idx].rob_id;
    assign issue_payload = entries[sel_idx].payload;

    always_ff @(posedge clk)
    begin
        if (rst)
            busy <= '0;
        else
        begin
            if (issue_valid)
                busy[sel_idx] <= 1'b0;       // freed at the issue edge
            if (disp_we && !full)
                busy[free_idx] <= 1'b1;      // strobe into a full station is dropped
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < DEPTH; i++)
        begin
            if (busy[i])
            begin
                entries[i].src1 <= wake(entries[i].src1, cdb, ext_wake);
                entries[i].src2 <= wake(entries[i].src2, cdb, ext_wake);
            end
        end
        if (disp_we && !full)
            entries[free_idx] <= new_entry;
    end

endmodule

// File: rtl/ooo_issue_pkg.sv
`include "ooo_settings.svh"

package ooo_issue_pkg;

    typedef logic [`PTAG_BITS-1:0] ptag_t;
    typedef logic [`ROB_BITS-1:0]  rob_id_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT                          // signed less-than
    } add_op_t;

    typedef enum logic {
        OP_MUL,                         // low word of product
        OP_MULHU                        // high word, unsigned
    } mul_op_t;

    typedef enum logic {
        UNIT_ADD,
        UNIT_MUL
    } unit_sel_t;

    typedef struct packed {
        ptag_t       tag;
        logic        ready;
        logic [31:0] value;             // only meaningful once ready
    } src_t;

    typedef struct packed {
        logic        valid;
        unit_sel_t   unit_sel;
        src_t        src1;
        src_t        src2;
        ptag_t       pd;
        rob_id_t     rob_id;
        add_op_t     add_op;
        mul_op_t     mul_op;
    } dispatch_t;

    // shared by the bus, the external wakeup and both unit results
    typedef struct packed {
        logic        valid;
        ptag_t       pd;
        rob_id_t     rob_id;
        logic [31:0] value;
    } cdb_t;

endpackage

// File: rtl/ooo_settings.svh
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// station sizes
`define ADD_RS_DEPTH 4
`define MUL_RS_DEPTH 2

// physical register tag and reorder buffer id widths
`define PTAG_BITS 6
`define ROB_BITS 5

// one shift-add step per multiplier bit
`define MUL_ITERS 32

`endif
